// ==== project.f ====
logic/dme_pkg.sv
logic/tlb.sv
logic/stb.sv
logic/dca.sv
logic/dme.sv
tests/tb_clock.sv
tests/dme_tb.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= dme_tb
FILE_LIST   ?= project.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_TEXT   ?= Test completed successfully
VFLAGS      ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/dme_tb.sv ====
`timescale 1ns/1ps

module dme_tb import dme_pkg::*;;

    localparam int N_REQ     = 400;
    localparam int TIMEOUT   = N_REQ * 50;   // about 50 cycles per request
    localparam int RST_CYCLES = 16;

    logic           clk;
    logic           i_rst_n;
    logic [0:0]     i_rnd;
    logic           i_req;
    mem_control_t   i_control;
    logic [31:0]    i_virtual_addr;
    logic [31:0]    i_write_data;
    logic           i_tlb_write;
    logic [19:0]    i_tlb_vpn;
    logic [7:0]     i_tlb_ppn;
    logic           o_ready;
    logic           o_load_valid;
    logic [31:0]    o_load_data;
    logic           o_tlb_miss;
    logic           o_mem_req;
    mem_req_t       o_mem;
    logic           i_mem_resp;
    logic [127:0]   i_mem_line;

    integer         seed = 32'h3a67e6d0;
    int             cycles;
    logic [7:0]     mem_model [int];
    logic [7:0]     shadow [int];
    logic [7:0]     ref_ppn [int];
    logic [31:0]    exp_q [$];
    logic [19:0]    st_addr_q [$];
    logic [31:0]    st_data_q [$];
    access_size_t   st_size_q [$];
    int             miss_pending;
    logic           fill_pending;
    int             fill_wait;
    logic [19:0]    fill_addr;
    logic [19:0]    load_line;

    tb_clock #(.PERIOD_NS(10.0)) u_clock (.o_clk(clk));

    dme #(
        .TLB_LINES(8), .CACHE_SECTORS(2), .CACHE_LINES(8), .CACHE_BYTES(16),
        .STB_LINES(4), .REG_WIDTH(32), .VA_WIDTH(32), .PA_WIDTH(20), .PAGE_BITS(12)
    ) dut0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_rnd(i_rnd),
        .i_req(i_req), .i_control(i_control), .i_virtual_addr(i_virtual_addr),
        .i_write_data(i_write_data),
        .i_tlb_write(i_tlb_write), .i_tlb_vpn(i_tlb_vpn), .i_tlb_ppn(i_tlb_ppn),
        .o_ready(o_ready), .o_load_valid(o_load_valid), .o_load_data(o_load_data),
        .o_tlb_miss(o_tlb_miss), .o_mem_req(o_mem_req), .o_mem(o_mem),
        .i_mem_resp(i_mem_resp), .i_mem_line(i_mem_line)
    );

    // background contents mixing every address bit
    function automatic logic [7:0] fill_byte(input logic [19:0] a);
        return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]} ^ 8'h5a;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [19:0] a);
        return shadow.exists(int'(a)) ? shadow[int'(a)] : fill_byte(a);
    endfunction

    function automatic logic [7:0] model_byte(input logic [19:0] a);
        return mem_model.exists(int'(a)) ? mem_model[int'(a)] : fill_byte(a);
    endfunction

    function automatic logic [31:0] expected_load(input logic [19:0] pa,
                                                  input mem_control_t ctl);
        logic [31:0] raw;
        logic        sign;
        raw = {shadow_byte(pa + 20'd3), shadow_byte(pa + 20'd2),
               shadow_byte(pa + 20'd1), shadow_byte(pa)};
        case (ctl.size)
            SIZE_BYTE: begin
                sign = raw[7] && !ctl.use_unsigned;
                return {{24{sign}}, raw[7:0]};
            end
            SIZE_HALF: begin
                sign = raw[15] && !ctl.use_unsigned;
                return {{16{sign}}, raw[15:0]};
            end
            default: return raw;
        endcase
    endfunction

    function automatic int size_bytes(input access_size_t s);
        return s == SIZE_BYTE ? 1 : (s == SIZE_HALF ? 2 : 4);
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic step();
        @(negedge clk);
        i_rnd = 1'($random(seed));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            step();
            i_req       = 1'b0;
            i_tlb_write = 1'b0;
        end
    endtask

    task automatic map_page(input logic [19:0] vpn, input logic [7:0] ppn);
        step();
        i_req       = 1'b0;
        i_tlb_write = 1'b1;
        i_tlb_vpn   = vpn;
        i_tlb_ppn   = ppn;
        ref_ppn[int'(vpn)] = ppn;
        step();
        i_tlb_write = 1'b0;
    endtask

    // holds the request until o_ready lets it in, then books the expectation
    task automatic issue(input logic is_load, input access_size_t sz, input logic uns,
                         input logic [31:0] va, input logic [31:0] data);
        logic        ok;
        logic [19:0] pa;
        int          vpn;
        ok = 1'b0;
        while (!ok) begin
            step();
            i_req          = 1'b1;
            i_control      = '{is_load: is_load, is_store: !is_load, size: sz,
                               use_unsigned: uns};
            i_virtual_addr = va;
            i_write_data   = data;
            @(posedge clk);
            ok = o_ready;
        end
        vpn = int'(va[31:12]);
        if (!ref_ppn.exists(vpn)) begin
            miss_pending++;
        end else begin
            pa = {ref_ppn[vpn], va[11:0]};
            if (is_load) begin
                exp_q.push_back(expected_load(pa, i_control));
                load_line = {pa[19:4], 4'h0};
            end else begin
                for (int b = 0; b < size_bytes(sz); b++) begin
                    shadow[int'(pa + 20'(b))] = data[b*8 +: 8];
                end
                st_addr_q.push_back(pa);
                st_data_q.push_back(data);
                st_size_q.push_back(sz);
            end
        end
    endtask

    function automatic logic [31:0] rand_va(input logic [31:0] r, input logic [2:0] page,
                                            input access_size_t sz);
        logic [31:0] va;
        va = {20'h00010 + 20'(page), r[11:10], 3'b000, r[6:0]};
        if (sz == SIZE_WORD) va[1:0] = 2'b00;
        if (sz == SIZE_HALF) va[0] = 1'b0;
        return va;
    endfunction

    // checks every output at the rising edge
    always @(posedge clk) begin
        logic [31:0] exp;
        if (i_rst_n) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_fail("timeout, the DUT stopped answering");
            end
            if (o_load_valid) begin
                assert (exp_q.size() > 0) else report_fail("load result with no load pending");
                exp = exp_q.pop_front();
                assert (o_load_data == exp) else
                    report_fail($sformatf("Fail o_load_data: got %h expected %h",
                                          o_load_data, exp));
            end
            if (o_tlb_miss) begin
                assert (miss_pending > 0) else report_fail("unexpected TLB miss");
                miss_pending--;
            end
            if (o_mem_req && o_mem.write) begin
                assert (st_addr_q.size() > 0) else report_fail("memory write with no store");
                assert (o_mem.addr == st_addr_q[0]) else
                    report_fail($sformatf("Fail o_mem.addr: got %h expected %h",
                                          o_mem.addr, st_addr_q[0]));
                assert (o_mem.data == st_data_q[0]) else
                    report_fail($sformatf("Fail o_mem.data: got %h expected %h",
                                          o_mem.data, st_data_q[0]));
                for (int b = 0; b < size_bytes(st_size_q[0]); b++) begin
                    mem_model[int'(o_mem.addr + 20'(b))] = o_mem.data[b*8 +: 8];
                end
                void'(st_addr_q.pop_front());
                void'(st_data_q.pop_front());
                void'(st_size_q.pop_front());
            end else if (o_mem_req) begin
                assert (!fill_pending) else report_fail("second line fill while one is open");
                assert (o_mem.addr == load_line) else
                    report_fail($sformatf("Fail o_mem.addr: got %h expected %h",
                                          o_mem.addr, load_line));
                fill_pending = 1'b1;
                fill_addr    = o_mem.addr;
                fill_wait    = 1 + ($unsigned($random(seed)) % 6);
            end
        end
    end

    // memory read answers
    always @(negedge clk) begin
        i_mem_resp = 1'b0;
        if (fill_pending) begin
            if (fill_wait > 1) begin
                fill_wait--;
            end else begin
                for (int b = 0; b < 16; b++) begin
                    i_mem_line[b*8 +: 8] = model_byte(fill_addr + 20'(b));
                end
                i_mem_resp   = 1'b1;
                fill_pending = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0]  r;
        logic [31:0]  va;
        access_size_t sz;
        i_rst_n        = 1'b0;
        i_rnd          = 1'b0;
        i_req          = 1'b0;
        i_control      = '0;
        i_virtual_addr = '0;
        i_write_data   = '0;
        i_tlb_write    = 1'b0;
        i_tlb_vpn      = '0;
        i_tlb_ppn      = '0;
        i_mem_resp     = 1'b0;
        i_mem_line     = '0;
        cycles         = 0;
        miss_pending   = 0;
        fill_pending   = 1'b0;
        fill_wait      = 0;
        fill_addr      = '0;
        load_line      = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        assert (o_ready && !o_load_valid && !o_tlb_miss && !o_mem_req) else
            report_fail("outputs not idle after reset");
        for (int p = 0; p < 6; p++) begin
            map_page(20'h00010 + 20'(p), 8'(p * 3 + 1));
        end
        for (int pass = 0; pass < 2; pass++) begin   // misses first, then hits
            for (int s = 0; s < 3; s++) begin
                issue(1'b1, access_size_t'(s), 1'b0, 32'h0001_0084, '0);
                issue(1'b1, access_size_t'(s), 1'b1,
                      s == 2 ? 32'h0001_0088 : 32'h0001_0086, '0);
                issue(1'b1, access_size_t'(s), 1'b1, 32'h0001_1040, '0);
            end
        end
        issue(1'b1, SIZE_WORD, 1'b0, 32'h0002_0010, '0);   // tag mismatch in slot 0
        issue(1'b0, SIZE_WORD, 1'b0, 32'h0001_6020, 32'h1234_5678);
        issue(1'b1, SIZE_WORD, 1'b0, 32'h0001_0084, '0);
        issue(1'b0, SIZE_HALF, 1'b0, 32'h0001_2102, 32'h0000_f00d);
        issue(1'b1, SIZE_HALF, 1'b0, 32'h0001_2102, '0);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h0001_3200, 32'h89ab_cdef);
        issue(1'b1, SIZE_BYTE, 1'b1, 32'h0001_3201, '0);
        issue(1'b0, SIZE_BYTE, 1'b0, 32'h0001_3203, 32'h0000_0080);
        issue(1'b1, SIZE_WORD, 1'b0, 32'h0001_3200, '0);
        idle(3);
        for (int n = 0; n < N_REQ - 40; n++) begin
            r  = $random(seed);
            sz = access_size_t'(r[13:12] == 2'd3 ? 2'd2 : r[13:12]);
            va = rand_va($random(seed), 3'(r[18:16] % 6), sz);
            if (r[23:20] == 4'hf) begin
                va[31:12] = 20'h00016;   // never mapped
            end
            issue(r[2:0] < 3'd5, sz, r[7], va, $random(seed));
            if (r[27:25] == 3'd0) begin
                idle(2);
            end
        end
        idle(1);
        while (exp_q.size() > 0 || st_addr_q.size() > 0 || miss_pending > 0 || fill_pending) begin
            step();
        end
        idle(4);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

endmodule

// ==== logic/dme.sv ====
`timescale 1ns/1ps

module dme import dme_pkg::*; #(
    parameter int TLB_LINES     = 8,
    parameter int CACHE_SECTORS = 2,
    parameter int CACHE_LINES   = 8,
    parameter int CACHE_BYTES   = 16,
    parameter int STB_LINES     = 4,
    parameter int REG_WIDTH     = PKG_REG_WIDTH,
    parameter int VA_WIDTH      = 32,
    parameter int PA_WIDTH      = PKG_PA_WIDTH,
    parameter int PAGE_BITS     = 12,
    localparam int WAY_WIDTH    = $clog2(CACHE_SECTORS),
    localparam int VPN_WIDTH    = VA_WIDTH - PAGE_BITS,
    localparam int PPN_WIDTH    = PA_WIDTH - PAGE_BITS,
    localparam int LINE_WIDTH   = CACHE_BYTES * 8
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic [WAY_WIDTH-1:0]    i_rnd,

    input  logic                    i_req,
    input  mem_control_t            i_control,
    input  logic [VA_WIDTH-1:0]     i_virtual_addr,
    input  logic [REG_WIDTH-1:0]    i_write_data,

    input  logic                    i_tlb_write,
    input  logic [VPN_WIDTH-1:0]    i_tlb_vpn,
    input  logic [PPN_WIDTH-1:0]    i_tlb_ppn,

    output logic                    o_ready,
    output logic                    o_load_valid,
    output logic [REG_WIDTH-1:0]    o_load_data,
    output logic                    o_tlb_miss,

    output logic                    o_mem_req,
    output mem_req_t                o_mem,
    input  logic                    i_mem_resp,
    input  logic [LINE_WIDTH-1:0]   i_mem_line
);

    logic [PPN_WIDTH-1:0]   ppn;
    logic                   tlb_miss;
    logic [PA_WIDTH-1:0]    pa;
    logic                   accept;
    logic                   do_load;
    logic                   do_store;

    stb_entry_t             push_entry;
    stb_entry_t             drain_entry;
    logic                   drained;
    logic                   stb_full;
    logic                   fwd_hit;
    logic [REG_WIDTH-1:0]   fwd_data;
    logic                   conflict;

    logic                   wait_q;
    logic [PA_WIDTH-1:0]    wait_pa;
    mem_control_t           wait_ctl;
    logic [PA_WIDTH-1:0]    ld_pa;
    mem_control_t           ld_ctl;

    logic                   cache_load;
    logic                   cache_valid;
    logic [REG_WIDTH-1:0]   cache_data;
    logic                   cache_busy;

    logic                   fwd_q;
    logic [REG_WIDTH-1:0]   fwd_data_q;
    logic                   tlb_miss_q;

    assign pa       = {ppn, i_virtual_addr[PAGE_BITS-1:0]};
    assign accept   = i_req && o_ready;
    assign do_load  = accept && i_control.is_load && !tlb_miss;
    assign do_store = accept && i_control.is_store && !tlb_miss;
    assign o_ready  = !(wait_q || fwd_q || cache_busy) && !(stb_full && i_control.is_store);

    // a waiting load owns the STB compare and the cache port
    assign ld_pa      = wait_q ? wait_pa : pa;
    assign ld_ctl     = wait_q ? wait_ctl : i_control;
    assign cache_load = wait_q ? !conflict : (do_load && !fwd_hit && !conflict);

    assign push_entry = '{valid: 1'b1, size: i_control.size, pa: pa, data: i_write_data};

    assign o_load_valid = fwd_q || cache_valid;
    assign o_load_data  = fwd_q ? fwd_data_q : cache_data;
    assign o_tlb_miss   = tlb_miss_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wait_q     <= 1'b0;
            fwd_q      <= 1'b0;
            tlb_miss_q <= 1'b0;
        end else begin
            fwd_q      <= do_load && fwd_hit;
            tlb_miss_q <= accept && (i_control.is_load || i_control.is_store) && tlb_miss;
            if (do_load && conflict) begin
                wait_q <= 1'b1;
            end else if (wait_q && !conflict) begin
                wait_q <= 1'b0;   // matching stores gone
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_load) begin
            wait_pa    <= pa;
            wait_ctl   <= i_control;
            fwd_data_q <= extend_load(fwd_data, i_control.size, i_control.use_unsigned);
        end
    end

    tlb #(
        .TLB_LINES(TLB_LINES),
        .VA_WIDTH(VA_WIDTH),
        .PA_WIDTH(PA_WIDTH),
        .PAGE_BITS(PAGE_BITS)
    ) u_tlb (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_write(i_tlb_write),
        .i_write_vpn(i_tlb_vpn),
        .i_write_ppn(i_tlb_ppn),
        .i_lookup_vpn(i_virtual_addr[VA_WIDTH-1:PAGE_BITS]),
        .o_physical_page(ppn),
        .o_miss(tlb_miss)
    );

    stb #(
        .STB_LINES(STB_LINES),
        .REG_WIDTH(REG_WIDTH),
        .PA_WIDTH(PA_WIDTH)
    ) u_stb (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_push(do_store),
        .i_entry(push_entry),
        .i_load_addr(ld_pa),
        .i_load_size(ld_ctl.size),
        .i_drained(drained),
        .o_drain(drain_entry),
        .o_full(stb_full),
        .o_fwd_hit(fwd_hit),
        .o_fwd_data(fwd_data),
        .o_conflict(conflict)
    );

    dca #(
        .CACHE_SECTORS(CACHE_SECTORS),
        .CACHE_LINES(CACHE_LINES),
        .CACHE_BYTES(CACHE_BYTES),
        .REG_WIDTH(REG_WIDTH),
        .PA_WIDTH(PA_WIDTH)
    ) u_dca (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_rnd(i_rnd),
        .i_load(cache_load),
        .i_control(ld_ctl),
        .i_pa(ld_pa),
        .i_drain(drain_entry),
        .o_drained(drained),
        .o_load_valid(cache_valid),
        .o_load_data(cache_data),
        .o_busy(cache_busy),
        .o_mem_req(o_mem_req),
        .o_mem(o_mem),
        .i_mem_resp(i_mem_resp),
        .i_mem_line(i_mem_line)
    );

endmodule

// ==== logic/dca.sv ====
`timescale 1ns/1ps

module dca import dme_pkg::*; #(
    parameter int CACHE_SECTORS,
    parameter int CACHE_LINES,
    parameter int CACHE_BYTES,
    parameter int REG_WIDTH,
    parameter int PA_WIDTH,
    localparam int WAY_WIDTH  = $clog2(CACHE_SECTORS),
    localparam int IDX_WIDTH  = $clog2(CACHE_LINES),
    localparam int OFF_WIDTH  = $clog2(CACHE_BYTES),
    localparam int TAG_WIDTH  = PA_WIDTH - IDX_WIDTH - OFF_WIDTH,
    localparam int LINE_WIDTH = CACHE_BYTES * 8,
    localparam int REG_BYTES  = REG_WIDTH / 8
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic [WAY_WIDTH-1:0]    i_rnd,

    input  logic                    i_load,
    input  mem_control_t            i_control,
    input  logic [PA_WIDTH-1:0]     i_pa,

    input  stb_entry_t              i_drain,
    output logic                    o_drained,

    output logic                    o_load_valid,
    output logic [REG_WIDTH-1:0]    o_load_data,
    output logic                    o_busy,

    output logic                    o_mem_req,
    output mem_req_t                o_mem,
    input  logic                    i_mem_resp,
    input  logic [LINE_WIDTH-1:0]   i_mem_line
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL
    } state_t;

    state_t                                     state;
    logic [CACHE_SECTORS-1:0][CACHE_LINES-1:0]  valid;
    logic [TAG_WIDTH-1:0]                       tags  [CACHE_SECTORS][CACHE_LINES];
    logic [LINE_WIDTH-1:0]                      lines [CACHE_SECTORS][CACHE_LINES];

    logic [PA_WIDTH-1:0]    req_pa;
    mem_control_t           req_ctl;
    logic [WAY_WIDTH-1:0]   victim;

    logic                   ld_hit;
    logic [WAY_WIDTH-1:0]   ld_way;
    logic [IDX_WIDTH-1:0]   ld_idx;
    logic [LINE_WIDTH-1:0]  ld_line;
    logic [REG_WIDTH-1:0]   ld_word;

    logic                   st_hit;
    logic [WAY_WIDTH-1:0]   st_way;
    logic [IDX_WIDTH-1:0]   st_idx;
    logic [REG_BYTES-1:0]   st_mask;

    function automatic logic [WAY_WIDTH:0] find_way(input logic [PA_WIDTH-1:0] pa);
        logic [WAY_WIDTH:0] result;
        result = '0;
        for (int w = 0; w < CACHE_SECTORS; w++) begin
            if (valid[w][pa[OFF_WIDTH +: IDX_WIDTH]] &&
                tags[w][pa[OFF_WIDTH +: IDX_WIDTH]] == pa[PA_WIDTH-1 -: TAG_WIDTH]) begin
                result = {1'b1, WAY_WIDTH'(w)};
            end
        end
        return result;
    endfunction

    always_comb begin
        {ld_hit, ld_way} = find_way(req_pa);
        {st_hit, st_way} = find_way(i_drain.pa);
    end

    assign ld_idx  = req_pa[OFF_WIDTH +: IDX_WIDTH];
    assign st_idx  = i_drain.pa[OFF_WIDTH +: IDX_WIDTH];
    assign ld_line = lines[ld_way][ld_idx];
    assign ld_word = ld_line[req_pa[OFF_WIDTH-1:2]*REG_WIDTH +: REG_WIDTH]
                     >> {req_pa[1:0], 3'b000};   // byte lane down to bit 0

    always_comb begin
        case (i_drain.size)
            SIZE_BYTE: st_mask = REG_BYTES'(1);
            SIZE_HALF: st_mask = REG_BYTES'(3);
            default:   st_mask = '1;
        endcase
    end

    assign o_busy       = state != ST_IDLE;
    assign o_drained    = state == ST_IDLE && i_drain.valid;
    assign o_load_valid = state == ST_LOOKUP && ld_hit;
    assign o_load_data  = extend_load(ld_word, req_ctl.size, req_ctl.use_unsigned);

    // write through on drain, line read on a load miss
    always_comb begin
        o_mem_req   = o_drained || (state == ST_LOOKUP && !ld_hit);
        o_mem.write = o_drained;
        o_mem.addr  = o_drained ? i_drain.pa
                                : {req_pa[PA_WIDTH-1:OFF_WIDTH], OFF_WIDTH'(0)};
        o_mem.data  = i_drain.data;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
            valid <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_load) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state <= ld_hit ? ST_IDLE : ST_FILL;
                end
                ST_FILL: begin
                    if (i_mem_resp) begin
                        valid[victim][ld_idx] <= 1'b1;
                        state                 <= ST_LOOKUP;   // replay hits now
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_load) begin
            req_pa  <= i_pa;
            req_ctl <= i_control;
        end
        if (state == ST_LOOKUP && !ld_hit) begin
            victim <= i_rnd;
        end
        if (state == ST_FILL && i_mem_resp) begin
            tags[victim][ld_idx]  <= req_pa[PA_WIDTH-1 -: TAG_WIDTH];
            lines[victim][ld_idx] <= i_mem_line;
        end
        if (o_drained && st_hit) begin
            for (int b = 0; b < REG_BYTES; b++) begin
                if (st_mask[b]) begin
                    lines[st_way][st_idx][(int'(i_drain.pa[OFF_WIDTH-1:0]) + b)*8 +: 8]
                        <= i_drain.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/stb.sv ====
`timescale 1ns/1ps

module stb import dme_pkg::*; #(
    parameter int STB_LINES,
    parameter int REG_WIDTH,
    parameter int PA_WIDTH,
    localparam int PTR_WIDTH = $clog2(STB_LINES)
) (
    input  logic                    clk,
    input  logic                    i_rst_n,

    input  logic                    i_push,
    input  stb_entry_t              i_entry,

    input  logic [PA_WIDTH-1:0]     i_load_addr,
    input  access_size_t            i_load_size,

    input  logic                    i_drained,
    output stb_entry_t              o_drain,

    output logic                    o_full,
    output logic                    o_fwd_hit,
    output logic [REG_WIDTH-1:0]    o_fwd_data,
    output logic                    o_conflict
);

    stb_entry_t             slots [STB_LINES];
    logic [STB_LINES-1:0]   used;
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            used   <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_drained) begin
                used[rd_ptr] <= 1'b0;
                rd_ptr       <= rd_ptr + PTR_WIDTH'(1);
            end
            if (i_push) begin
                used[wr_ptr] <= 1'b1;
                wr_ptr       <= wr_ptr + PTR_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            slots[wr_ptr] <= i_entry;
        end
    end

    always_comb begin
        o_drain       = slots[rd_ptr];
        o_drain.valid = used[rd_ptr];   // oldest entry
    end

    assign o_full = &used;

    // youngest store to the load word decides
    always_comb begin
        logic                 found;
        logic [PTR_WIDTH-1:0] idx;
        found      = 1'b0;
        o_fwd_hit  = 1'b0;
        o_conflict = 1'b0;
        o_fwd_data = '0;
        for (int i = 1; i <= STB_LINES; i++) begin
            idx = wr_ptr - PTR_WIDTH'(i);
            if (!found && used[idx] &&
                slots[idx].pa[PA_WIDTH-1:2] == i_load_addr[PA_WIDTH-1:2]) begin
                found = 1'b1;
                if (slots[idx].pa[1:0] == i_load_addr[1:0] &&
                    slots[idx].size == i_load_size) begin
                    o_fwd_hit  = 1'b1;
                    o_fwd_data = slots[idx].data;
                end else begin
                    o_conflict = 1'b1;   // partial overlap waits for the drain
                end
            end
        end
    end

endmodule

// ==== logic/tlb.sv ====
`timescale 1ns/1ps

module tlb #(
    parameter int TLB_LINES,
    parameter int VA_WIDTH,
    parameter int PA_WIDTH,
    parameter int PAGE_BITS,
    localparam int VPN_WIDTH = VA_WIDTH - PAGE_BITS,
    localparam int PPN_WIDTH = PA_WIDTH - PAGE_BITS,
    localparam int IDX_WIDTH = $clog2(TLB_LINES),
    localparam int TAG_WIDTH = VPN_WIDTH - IDX_WIDTH
) (
    input  logic                    clk,
    input  logic                    i_rst_n,

    input  logic                    i_write,
    input  logic [VPN_WIDTH-1:0]    i_write_vpn,
    input  logic [PPN_WIDTH-1:0]    i_write_ppn,

    input  logic [VPN_WIDTH-1:0]    i_lookup_vpn,
    output logic [PPN_WIDTH-1:0]    o_physical_page,
    output logic                    o_miss
);

    logic [TLB_LINES-1:0]   valid;
    logic [TAG_WIDTH-1:0]   tags [TLB_LINES];
    logic [PPN_WIDTH-1:0]   ppns [TLB_LINES];
    logic [IDX_WIDTH-1:0]   write_idx;
    logic [IDX_WIDTH-1:0]   lookup_idx;

    assign write_idx  = i_write_vpn[IDX_WIDTH-1:0];
    assign lookup_idx = i_lookup_vpn[IDX_WIDTH-1:0];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid <= '0;
        end else if (i_write) begin
            valid[write_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_write) begin
            tags[write_idx] <= i_write_vpn[VPN_WIDTH-1:IDX_WIDTH];
            ppns[write_idx] <= i_write_ppn;   // older mapping in the slot is lost
        end
    end

    assign o_physical_page = ppns[lookup_idx];
    assign o_miss          = !(valid[lookup_idx] &&
                               tags[lookup_idx] == i_lookup_vpn[VPN_WIDTH-1:IDX_WIDTH]);

endmodule

// ==== logic/dme_pkg.sv ====
package dme_pkg;

    localparam int PKG_REG_WIDTH = 32;
    localparam int PKG_PA_WIDTH  = 20;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    typedef struct packed {
        logic           is_load;
        logic           is_store;
        access_size_t   size;
        logic           use_unsigned;
    } mem_control_t;

    typedef struct packed {
        logic                       valid;
        access_size_t               size;
        logic [PKG_PA_WIDTH-1:0]    pa;
        logic [PKG_REG_WIDTH-1:0]   data;   // store value in the low bits
    } stb_entry_t;

    typedef struct packed {
        logic                       write;  // set for a single store
        logic [PKG_PA_WIDTH-1:0]    addr;   // line aligned on fills
        logic [PKG_REG_WIDTH-1:0]   data;
    } mem_req_t;

    // low byte or half of value, widened to a full register
    function automatic logic [PKG_REG_WIDTH-1:0] extend_load(
        input logic [PKG_REG_WIDTH-1:0] value,
        input access_size_t             size,
        input logic                     use_unsigned
    );
        logic [PKG_REG_WIDTH-1:0] result;
        case (size)
            SIZE_BYTE: result = {{(PKG_REG_WIDTH-8){value[7] & !use_unsigned}}, value[7:0]};
            SIZE_HALF: result = {{(PKG_REG_WIDTH-16){value[15] & !use_unsigned}}, value[15:0]};
            default:   result = value;
        endcase
        return result;
    endfunction

endpackage
